// File: icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// pc and axi address width
`define ICACHE_ADDR_W 32

// one instruction per line
`define ICACHE_DATA_W 32

// power of two, selected by the low word-address bits
`define ICACHE_NUM_BANKS 4

// power of two
`define ICACHE_LINES 32

`endif

// File: axi_lite_pkg.sv
`include "icache_macros.svh"

package axi_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // read address channel payload
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] araddr;
        logic [2:0]                arprot;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [`ICACHE_DATA_W-1:0] rdata;
        axi_resp_e                 rresp;
    } axi_r_t;

endpackage

// File: icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // pc layout from the low end: byte offset, bank, index, tag
    localparam int BANK_W  = $clog2(`ICACHE_NUM_BANKS);
    localparam int INDEX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W   = `ICACHE_ADDR_W - 2 - BANK_W - INDEX_W;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] pc;
        logic [`ICACHE_DATA_W-1:0] instr;
        logic                      err;
    } fetch_resp_t;

    // word-aligned line address
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } miss_req_t;

    typedef struct packed {
        logic [`ICACHE_DATA_W-1:0] instr;
        logic                      err;
    } refill_t;

    function automatic logic [BANK_W-1:0] pc_bank(input logic [`ICACHE_ADDR_W-1:0] pc);
        return pc[2 +: BANK_W];
    endfunction

    function automatic logic [INDEX_W-1:0] pc_index(input logic [`ICACHE_ADDR_W-1:0] pc);
        return pc[2 + BANK_W +: INDEX_W];
    endfunction

    function automatic logic [TAG_W-1:0] pc_tag(input logic [`ICACHE_ADDR_W-1:0] pc);
        return pc[`ICACHE_ADDR_W-1 -: TAG_W];
    endfunction

endpackage

// File: bank_dispatch.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module bank_dispatch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  icache_pkg::fetch_req_t            req,
    input  logic [`ICACHE_NUM_BANKS-1:0]      bank_busy,
    output logic [`ICACHE_NUM_BANKS-1:0]      bank_req_valid,
    output icache_pkg::fetch_req_t            bank_req
);
    import icache_pkg::*;

    localparam int NB = `ICACHE_NUM_BANKS;

    logic              ready_q;
    logic [BANK_W-1:0] sel;
    logic              accept;

    assign sel = pc_bank(req.pc);

    // a bank with a request already in the dispatch register counts as busy
    assign req_ready = ready_q && !flush && !bank_busy[sel] && !bank_req_valid[sel];
    assign accept    = req_valid && req_ready;

    // held low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            bank_req_valid <= '0;
        end else if (accept) begin
            bank_req_valid <= NB'(1) << sel;
        end else begin
            bank_req_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bank_req <= req;
        end
    end

endmodule

// File: icache_bank.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    req_valid,
    input  icache_pkg::fetch_req_t  req,
    output logic                    busy,
    output logic                    hit_valid,
    input  logic                    hit_ready,
    output icache_pkg::fetch_resp_t hit_resp,
    output logic                    miss_valid,
    input  logic                    miss_ready,
    output icache_pkg::miss_req_t   miss_req,
    input  logic                    refill_valid,
    input  icache_pkg::refill_t     refill
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_WAIT,
        S_RESP
    } state_e;

    state_e                    state;
    fetch_req_t                hold_q;
    fetch_resp_t               resp_q;
    logic [`ICACHE_LINES-1:0]  valid_q;
    logic [TAG_W-1:0]          tag_mem [`ICACHE_LINES];
    logic [`ICACHE_DATA_W-1:0] data_mem [`ICACHE_LINES];
    logic [INDEX_W-1:0]        idx;
    logic                      tag_hit;
    logic                      fill_en;
    logic                      wr_en;

    assign idx     = pc_index(hold_q.pc);
    assign tag_hit = valid_q[idx] && (tag_mem[idx] == pc_tag(hold_q.pc));

    // error words are forwarded but never cached
    assign fill_en = (state == S_WAIT) && refill_valid && !flush;
    assign wr_en   = fill_en && !refill.err;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   if (req_valid) state <= S_LOOKUP;
                S_LOOKUP: state <= tag_hit ? S_RESP : S_MISS;
                S_MISS:   if (miss_ready) state <= S_WAIT;
                S_WAIT:   if (refill_valid) state <= S_RESP;
                S_RESP:   if (hit_ready) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[idx]  <= pc_tag(hold_q.pc);
            data_mem[idx] <= refill.instr;
        end
    end

    // holding register and response word
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            hold_q <= req;
        end
        if (state == S_LOOKUP) begin
            resp_q.pc    <= hold_q.pc;
            resp_q.instr <= data_mem[idx];
            resp_q.err   <= 1'b0;
        end else if (fill_en) begin
            resp_q.pc    <= hold_q.pc;
            resp_q.instr <= refill.instr;
            resp_q.err   <= refill.err;
        end
    end

    assign busy          = (state != S_IDLE);
    assign hit_valid     = (state == S_RESP);
    assign miss_valid    = (state == S_MISS);
    assign hit_resp      = resp_q;
    assign miss_req.addr = {hold_q.pc[`ICACHE_ADDR_W-1:2], 2'b00};

endmodule

// File: miss_arbiter.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module miss_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic [`ICACHE_NUM_BANKS-1:0]  hit_valid,
    output logic [`ICACHE_NUM_BANKS-1:0]  hit_ready,
    input  icache_pkg::fetch_resp_t       hit_resp [`ICACHE_NUM_BANKS],
    input  logic [`ICACHE_NUM_BANKS-1:0]  miss_valid,
    output logic [`ICACHE_NUM_BANKS-1:0]  miss_ready,
    input  icache_pkg::miss_req_t         miss_req [`ICACHE_NUM_BANKS],
    output logic [`ICACHE_NUM_BANKS-1:0]  refill_valid,
    output icache_pkg::refill_t           refill,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output icache_pkg::fetch_resp_t       resp,
    output logic                          arvalid,
    input  logic                          arready,
    output axi_lite_pkg::axi_ar_t         ar,
    input  logic                          rvalid,
    output logic                          rready,
    input  axi_lite_pkg::axi_r_t          r
);
    import icache_pkg::*;
    import axi_lite_pkg::*;

    localparam int NB = `ICACHE_NUM_BANKS;

    typedef enum logic [1:0] {
        A_IDLE,
        A_AR,
        A_R
    } rd_state_e;

    rd_state_e         rd_state;
    logic [BANK_W-1:0] hit_ptr;
    logic [BANK_W-1:0] miss_ptr;
    logic [BANK_W-1:0] owner_q;
    logic [BANK_W:0]   hit_pick;
    logic [BANK_W:0]   miss_pick;
    logic              hit_go;
    logic              miss_go;
    logic              r_go;
    logic              drop_q;
    axi_ar_t           ar_q;
    refill_t           refill_q;

    // first requester at or after ptr, found flag on top
    function automatic logic [BANK_W:0] rr_pick(input logic [NB-1:0] vld,
                                                input logic [BANK_W-1:0] ptr);
        logic [BANK_W-1:0] cand;
        logic [BANK_W:0]   pick;
        pick = '0;
        for (int k = NB - 1; k >= 0; k--) begin
            cand = ptr + BANK_W'(k);
            if (vld[cand]) begin
                pick = {1'b1, cand};
            end
        end
        return pick;
    endfunction

    assign hit_pick  = rr_pick(hit_valid, hit_ptr);
    assign miss_pick = rr_pick(miss_valid, miss_ptr);

    assign resp_valid = hit_pick[BANK_W] && !flush;
    assign resp       = hit_resp[hit_pick[BANK_W-1:0]];
    assign hit_go     = resp_valid && resp_ready;
    assign hit_ready  = hit_go ? (NB'(1) << hit_pick[BANK_W-1:0]) : '0;

    // one read in flight at a time
    assign miss_go    = miss_pick[BANK_W] && (rd_state == A_IDLE) && !flush;
    assign miss_ready = miss_go ? (NB'(1) << miss_pick[BANK_W-1:0]) : '0;

    assign r_go    = (rd_state == A_R) && rvalid;
    assign arvalid = (rd_state == A_AR);
    assign rready  = (rd_state == A_R);
    assign ar      = ar_q;
    assign refill  = refill_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= A_IDLE;
            hit_ptr  <= '0;
            miss_ptr <= '0;
        end else begin
            if (hit_go) begin
                hit_ptr <= hit_pick[BANK_W-1:0] + 1'b1;
            end
            if (miss_go) begin
                miss_ptr <= miss_pick[BANK_W-1:0] + 1'b1;
            end
            case (rd_state)
                A_IDLE:  if (miss_go) rd_state <= A_AR;
                A_AR:    if (arready) rd_state <= A_R;
                A_R:     if (rvalid) rd_state <= A_IDLE;
                default: rd_state <= A_IDLE;
            endcase
        end
    end

    // a flush during the read marks its data stale
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_q <= 1'b0;
        end else if (r_go) begin
            drop_q <= 1'b0;
        end else if (flush && rd_state != A_IDLE) begin
            drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_valid <= '0;
        end else if (r_go && !drop_q && !flush) begin
            refill_valid <= NB'(1) << owner_q;
        end else begin
            refill_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_go) begin
            ar_q.araddr <= miss_req[miss_pick[BANK_W-1:0]].addr;
            // instruction, secure, unprivileged
            ar_q.arprot <= 3'b100;
            owner_q     <= miss_pick[BANK_W-1:0];
        end
        if (r_go) begin
            refill_q.instr <= r.rdata;
            refill_q.err   <= (r.rresp != OKAY);
        end
    end

endmodule

// File: icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  icache_pkg::fetch_req_t  req,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output icache_pkg::fetch_resp_t resp,
    output logic                    arvalid,
    input  logic                    arready,
    output axi_lite_pkg::axi_ar_t   ar,
    input  logic                    rvalid,
    output logic                    rready,
    input  axi_lite_pkg::axi_r_t    r
);
    import icache_pkg::*;

    localparam int NB = `ICACHE_NUM_BANKS;

    logic [NB-1:0] bank_req_valid;
    logic [NB-1:0] bank_busy;
    logic [NB-1:0] hit_valid;
    logic [NB-1:0] hit_ready;
    logic [NB-1:0] miss_valid;
    logic [NB-1:0] miss_ready;
    logic [NB-1:0] refill_valid;
    fetch_req_t    bank_req;
    fetch_resp_t   hit_resp [NB];
    miss_req_t     miss_req [NB];
    refill_t       refill;

    bank_dispatch u_bank_dispatch (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .bank_busy      (bank_busy),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req)
    );

    // bank i serves pcs whose bank field equals i
    for (genvar i = 0; i < NB; i++) begin : g_bank
        icache_bank u_icache_bank (
            .clk          (clk),
            .rst          (rst),
            .flush        (flush),
            .req_valid    (bank_req_valid[i]),
            .req          (bank_req),
            .busy         (bank_busy[i]),
            .hit_valid    (hit_valid[i]),
            .hit_ready    (hit_ready[i]),
            .hit_resp     (hit_resp[i]),
            .miss_valid   (miss_valid[i]),
            .miss_ready   (miss_ready[i]),
            .miss_req     (miss_req[i]),
            .refill_valid (refill_valid[i]),
            .refill       (refill)
        );
    end

    miss_arbiter u_miss_arbiter (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .hit_valid    (hit_valid),
        .hit_ready    (hit_ready),
        .hit_resp     (hit_resp),
        .miss_valid   (miss_valid),
        .miss_ready   (miss_ready),
        .miss_req     (miss_req),
        .refill_valid (refill_valid),
        .refill       (refill),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r)
    );

endmodule

// File: tb_icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache_top;
    import icache_pkg::*;
    import axi_lite_pkg::*;

    localparam int ADDR_W  = `ICACHE_ADDR_W;
    localparam int SLOT_W  = BANK_W + INDEX_W;
    localparam int TAG_LSB = 2 + SLOT_W;
    localparam int TIMEOUT = 2000;
    localparam logic [ADDR_W-1:0] PC_A      = 32'h0000_1234;
    localparam logic [ADDR_W-1:0] ERR_BASE  = 32'h0000_f000;
    localparam logic [ADDR_W-1:0] RAND_BASE = 32'h0000_4000;
    localparam logic [ADDR_W-1:0] RAND_MASK = 32'h0000_03fc;

    logic clk;
    logic rst;
    logic flush;
    logic req_valid;
    logic req_ready;
    fetch_req_t req;
    logic resp_valid;
    logic resp_ready;
    fetch_resp_t resp;
    logic arvalid;
    logic arready;
    axi_ar_t ar;
    logic rvalid;
    logic rready;
    axi_r_t r;

    int seed = 32'h9f54_f309;
    int errors = 0;
    int ar_count = 0;
    int ar_base;
    int exp_ar;
    int err_base;
    int test_count = 0;
    int fail_count = 0;
    string test_name;
    logic rr_random = 1'b0;
    logic [ADDR_W-1:0] exp_q [$];
    axi_ar_t ar_log [$];
    logic model_valid [1 << SLOT_W];
    logic [TAG_W-1:0] model_tag [1 << SLOT_W];

    icache_top u_icache_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory contents mix all address bits
    function automatic logic [`ICACHE_DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic in_err(input logic [ADDR_W-1:0] addr);
        return (addr >= ERR_BASE) && (addr < ERR_BASE + 32'h100);
    endfunction

    // tag array model returns true when the fetch must go to memory
    function automatic logic predict_miss(input logic [ADDR_W-1:0] pc);
        logic [SLOT_W-1:0] slot;
        logic [TAG_W-1:0]  tag;
        slot = pc[2 +: SLOT_W];
        tag  = pc[ADDR_W-1 -: TAG_W];
        if (model_valid[slot] && model_tag[slot] == tag) begin
            return 1'b0;
        end
        if (!in_err(pc)) begin
            model_valid[slot] = 1'b1;
            model_tag[slot]   = tag;
        end
        return 1'b1;
    endfunction

    function automatic void clear_model();
        for (int k = 0; k < (1 << SLOT_W); k++) begin
            model_valid[k] = 1'b0;
        end
    endfunction

    task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp);
        if (got !== exp) begin
            $display("[ERROR] resp pc %h: got instr %h err %h, exp instr %h err %h",
                     got.pc, got.instr, got.err, exp.instr, exp.err);
            errors++;
        end
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
        if (got !== exp) begin
            $display("[ERROR] ar got araddr %h arprot %h, exp araddr %h arprot %h",
                     got.araddr, got.arprot, exp.araddr, exp.arprot);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic match_resp(input fetch_resp_t got);
        int          idx;
        fetch_resp_t exp;
        idx = -1;
        for (int k = 0; k < exp_q.size(); k++) begin
            if (idx < 0 && exp_q[k] == got.pc) idx = k;
        end
        if (idx < 0) begin
            $display("response for pc %h that has no fetch outstanding", got.pc);
            errors++;
        end else begin
            exp.pc    = got.pc;
            exp.instr = mem_word(got.pc);
            exp.err   = in_err(got.pc);
            check_resp(got, exp);
            exp_q.delete(idx);
        end
    endtask

    // compare process samples ahead of the transfer edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && resp_valid && resp_ready) match_resp(resp);
        end
    end

    // axi4-lite read slave with random delays
    initial begin
        logic [31:0]       rnd;
        logic              ar_hs;
        logic              r_hs;
        logic              known;
        logic              rd_pending;
        logic [1:0]        rd_wait;
        logic [ADDR_W-1:0] rd_addr;
        arready    = 1'b0;
        rvalid     = 1'b0;
        r          = '0;
        rd_pending = 1'b0;
        rd_wait    = '0;
        rd_addr    = '0;
        forever begin
            @(negedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            if (ar_hs) begin
                ar_count++;
                ar_log.push_back(ar);
                rd_addr = ar.araddr;
                known   = 1'b0;
                foreach (exp_q[k]) begin
                    if ({exp_q[k][ADDR_W-1:2], 2'b00} == ar.araddr) known = 1'b1;
                end
                if (!known) begin
                    $display("read of address %h with no fetch outstanding", ar.araddr);
                    errors++;
                end
            end
            @(posedge clk);
            #1;
            rnd = $random(seed);
            if (r_hs) rvalid = 1'b0;
            if (rd_pending && !rvalid) begin
                if (rd_wait == 2'd0) begin
                    rvalid     = 1'b1;
                    r.rdata    = mem_word(rd_addr);
                    r.rresp    = in_err(rd_addr) ? SLVERR : OKAY;
                    rd_pending = 1'b0;
                end else begin
                    rd_wait = rd_wait - 2'd1;
                end
            end
            if (ar_hs) begin
                rd_pending = 1'b1;
                rd_wait    = rnd[1:0];
            end
            arready = !rd_pending && !rvalid && rnd[4];
        end
    end

    initial begin
        logic [31:0] rnd;
        resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd        = $random(seed);
            resp_ready = rr_random ? rnd[7] : 1'b1;
        end
    end

    task automatic send_fetch(input logic [ADDR_W-1:0] pc);
        int   cycles;
        logic taken;
        cycles    = 0;
        taken     = 1'b0;
        req_valid = 1'b1;
        req.pc    = pc;
        while (!taken && cycles < TIMEOUT) begin
            @(negedge clk);
            taken = req_ready;
            if (taken) begin
                exp_q.push_back(pc);
                if (predict_miss(pc)) exp_ar++;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        req_valid = 1'b0;
        if (!taken) begin
            $display("fetch of pc %h was never accepted", pc);
            errors++;
        end
    endtask

    // all responses back and the read channel idle
    task automatic drain();
        int   cycles;
        logic idle;
        cycles = 0;
        idle   = 1'b0;
        while (!idle && cycles < TIMEOUT) begin
            @(negedge clk);
            idle = (exp_q.size() == 0) && !arvalid && !rvalid && !resp_valid;
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!idle) begin
            $display("%0d fetches still without a response", exp_q.size());
            errors++;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic check_last_ar(input logic [ADDR_W-1:0] pc);
        axi_ar_t exp;
        exp.araddr = {pc[ADDR_W-1:2], 2'b00};
        exp.arprot = 3'b100;
        if (ar_log.size() == 0) begin
            $display("no read was issued for pc %h", pc);
            errors++;
        end else begin
            check_ar(ar_log[$], exp);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = errors;
        ar_base   = ar_count;
        exp_ar    = 0;
    endtask

    task automatic end_test();
        check_count("ar_count", ar_count - ar_base, exp_ar);
        test_count++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            fail_count++;
            $display("test %0d %s: FAIL, %0d errors", test_count, test_name, errors - err_base);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        clear_model();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("cold miss");
        send_fetch(PC_A);
        drain();
        check_last_ar(PC_A);
        end_test();

        begin_test("hit");
        send_fetch(PC_A);
        drain();
        end_test();

        begin_test("conflict eviction");
        send_fetch(PC_A ^ (ADDR_W'(1) << TAG_LSB));
        drain();
        check_last_ar(PC_A ^ (ADDR_W'(1) << TAG_LSB));
        send_fetch(PC_A);
        drain();
        check_last_ar(PC_A);
        end_test();

        begin_test("flush");
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        clear_model();
        send_fetch(PC_A);
        drain();
        check_last_ar(PC_A);
        end_test();

        begin_test("random traffic with back-pressure");
        rr_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            send_fetch(RAND_BASE | (rnd & RAND_MASK));
        end
        drain();
        rr_random = 1'b0;
        drain();
        end_test();

        // slave error words are never cached
        begin_test("read error");
        send_fetch(ERR_BASE + 32'h10);
        drain();
        send_fetch(ERR_BASE + 32'h10);
        drain();
        check_last_ar(ERR_BASE + 32'h10);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (200000) @(posedge clk);
        $display("simulation did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: icache_top.f
+incdir+.
axi_lite_pkg.sv
icache_pkg.sv
bank_dispatch.sv
icache_bank.sv
miss_arbiter.sv
icache_top.sv
tb_icache_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_icache_top
FILELIST  := icache_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
